/* files.f */
common/iadc_pkg.sv
iadc_infrastructure/iadc_infrastructure.sv
iadc_ctrl/iadc_ctrl_serial.sv
logic/iadc_capture.sv
logic/iadc_regs.sv
logic/iadc_top.sv
sim/iadc_tb.sv

/* sim/iadc_tb.sv */
`timescale 1ns/100ps

module iadc_tb;
  import iadc_pkg::*;

  localparam int          HIST_LEN   = 8192;
  localparam int          MAX_CYCLES = 20000;
  localparam int          OOR_WORDS  = 7;
  localparam int          IDLE_CHECK = 40;
  localparam logic [31:0] CMD_WORD   = 32'h0005_A5C3;    // address 5 with data a5c3

  logic                   adc_clk;
  logic                   rst_n;
  iadc_ddr_pins_t         pads;
  apb_req_t               apb_req;
  apb_rsp_t               apb_rsp;
  logic                   ctrl_clk;
  logic                   ctrl_data;
  logic                   ctrl_strobe_n;
  logic                   adc_mode;
  logic                   adc_ddrb;

  iadc_ddr_pins_t         rise_hist [HIST_LEN];      // pad values of each word on the rising edge
  iadc_ddr_pins_t         fall_hist [HIST_LEN];      // and on the falling edge after it
  int                     word_cnt   = 0;
  bit                     sync_req   = 0;
  int                     sync_word  = -1;
  int                     oor_left   = 0;
  int                     frame_cnt  = 0;
  int                     frame_bits = 0;
  iadc_ctrl_cmd_t         frame_cmd;
  logic [SAMPLE_BITS-1:0] cap_words [CAP_DEPTH];

  iadc_top DUT (
    .adc_clk       (adc_clk),
    .rst_n         (rst_n),
    .pads          (pads),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .ctrl_clk      (ctrl_clk),
    .ctrl_data     (ctrl_data),
    .ctrl_strobe_n (ctrl_strobe_n),
    .adc_mode      (adc_mode),
    .adc_ddrb      (adc_ddrb)
  );

  always #50 adc_clk = ~adc_clk;

  ////////////////////////////////////////
  // error reporting and reference model
  ////////////////////////////////////////
  task automatic fail_run;
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    fail_run();
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      fail_run();
    end
  endtask

  // the word holds i rise, i fall, q rise and q fall in that order with even before odd
  function automatic iadc_sample_t expected_sample(input iadc_ddr_pins_t rise,
                                                   input iadc_ddr_pins_t fall);
    iadc_sample_t s;
    s.data = {rise.data_i_even, rise.data_i_odd, fall.data_i_even, fall.data_i_odd,
              rise.data_q_even, rise.data_q_odd, fall.data_q_even, fall.data_q_odd};
    s.oor  = {fall.oor_i, fall.oor_q, rise.oor_i, rise.oor_q};
    s.sync = rise.sync;
    return s;
  endfunction

  function automatic iadc_ddr_pins_t random_pins();
    iadc_ddr_pins_t p;
    p             = '0;                                // oor and sync stay low by default
    p.data_i_even = ADC_BITS'($urandom);
    p.data_i_odd  = ADC_BITS'($urandom);
    p.data_q_even = ADC_BITS'($urandom);
    p.data_q_odd  = ADC_BITS'($urandom);
    return p;
  endfunction

  ////////////////////////////////////////
  // apb host
  ////////////////////////////////////////
  task automatic apb_access(input logic is_write, input logic [APB_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge adc_clk);
    apb_req.psel    <= 1'b1;                           // setup cycle
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= is_write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge adc_clk);
    apb_req.penable <= 1'b1;                           // access cycle
    waited = 0;
    @(negedge adc_clk);
    while (apb_rsp.pready !== 1'b1) begin
      waited++;
      if (waited > 16) report_error("APB completer never raised pready");
      @(negedge adc_clk);
    end
    rdata = apb_rsp.prdata;                            // sampled mid-cycle where it is stable
    err   = apb_rsp.pslverr;
    @(posedge adc_clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_BITS-1:0] addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [APB_ADDR_BITS-1:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_access(1'b0, addr, 32'h0, rdata, err);
  endtask

  task automatic wait_capture_done;
    logic [31:0] status;
    logic        err;
    int          polls;
    polls = 0;
    apb_read(REG_STATUS, status, err);
    while (!status[0]) begin
      polls++;
      if (polls > 100) report_error("snapshot capture never reported done");
      apb_read(REG_STATUS, status, err);
    end
  endtask

  task automatic read_buffer;
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    for (int n = 0; n < CAP_DEPTH; n++) begin
      apb_read(BUF_BASE + APB_ADDR_BITS'(8 * n), lo, err);
      check_value($sformatf("buffer low read pslverr %0d", n), 0, err);
      apb_read(BUF_BASE + APB_ADDR_BITS'(8 * n + 4), hi, err);
      check_value($sformatf("buffer high read pslverr %0d", n), 0, err);
      cap_words[n] = {hi, lo};
    end
  endtask

  ////////////////////////////////////////
  // ddr source and serial monitor
  ////////////////////////////////////////
  initial begin
    iadc_ddr_pins_t rise;
    iadc_ddr_pins_t fall;
    bit             oor_word;
    pads = '0;
    void'($urandom(32'h2d1f_e26f));
    forever begin
      @(negedge adc_clk);
      rise     = random_pins();
      oor_word = oor_left > 0;
      if (sync_req) begin
        rise.sync = 1'b1;                              // mark the one sync word and log its index
        sync_word = word_cnt;
        sync_req  = 1'b0;
      end
      if (oor_word) begin
        rise.oor_i = 1'b1;
        rise.oor_q = 1'($urandom);
        oor_left--;
      end
      pads <= rise;
      @(posedge adc_clk);
      fall = random_pins();
      if (oor_word) begin
        fall.oor_i = 1'($urandom);
        fall.oor_q = 1'($urandom);
      end
      pads <= fall;
      if (word_cnt >= HIST_LEN) report_error("source history ran out of space");
      rise_hist[word_cnt] = rise;
      fall_hist[word_cnt] = fall;
      word_cnt++;
    end
  end

  // pins are registered on adc_clk, so the falling edge sees them settled
  initial begin
    logic                     prev_strobe_n;
    logic                     prev_clk;
    logic [CTRL_CMD_BITS-1:0] shift;
    int                       bits;
    prev_strobe_n = 1'b1;
    prev_clk      = 1'b0;
    shift         = '0;
    bits          = 0;
    forever begin
      @(negedge adc_clk);
      if (rst_n === 1'b1) begin
        if (prev_strobe_n && !ctrl_strobe_n) begin
          shift = '0;
          bits  = 0;
        end
        if (!ctrl_strobe_n && !prev_clk && ctrl_clk) begin
          shift = {shift[CTRL_CMD_BITS-2:0], ctrl_data};   // msb first
          bits++;
        end
        if (!prev_strobe_n && ctrl_strobe_n) begin
          frame_cmd  = shift;
          frame_bits = bits;
          frame_cnt++;
        end
      end
      prev_strobe_n = ctrl_strobe_n;
      prev_clk      = ctrl_clk;
    end
  end

  initial begin
    repeat (MAX_CYCLES) @(posedge adc_clk);
    report_error("simulation did not finish within the cycle limit");
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0]  rdata;
    logic         err;
    int           base;
    int           frames_before;
    int           waited;
    iadc_sample_t exp_s;
    adc_clk = 1'b0;
    rst_n   = 1'b0;
    apb_req = '0;
    repeat (8) @(posedge adc_clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge adc_clk);

    // reset state
    apb_read(REG_STATUS, rdata, err);
    check_value("reset status", 0, rdata);
    check_value("reset status pslverr", 0, err);
    @(negedge adc_clk);
    check_value("reset strobe_n", 1, ctrl_strobe_n);
    check_value("reset ctrl_clk", 0, ctrl_clk);
    check_value("reset adc_mode", 0, adc_mode);
    check_value("reset adc_ddrb", 0, adc_ddrb);

    // register access
    apb_write(REG_CTRL, 32'h0000_000E, err);
    check_value("ctrl write pslverr", 0, err);
    apb_read(REG_CTRL, rdata, err);
    check_value("ctrl readback", 32'hE, rdata);
    @(negedge adc_clk);
    check_value("adc_mode set", 1, adc_mode);
    check_value("adc_ddrb set", 1, adc_ddrb);
    apb_write(REG_CTRL, 32'h0000_0009, err);           // arm and ddrb
    apb_read(REG_CTRL, rdata, err);
    check_value("ctrl readback with arm", 32'h8, rdata);
    @(negedge adc_clk);
    check_value("adc_mode cleared", 0, adc_mode);
    check_value("adc_ddrb held", 1, adc_ddrb);
    apb_read(8'h10, rdata, err);
    check_value("unmapped read pslverr", 1, err);
    check_value("unmapped read data", 0, rdata);
    apb_read(8'hC0, rdata, err);
    check_value("read past buffer pslverr", 1, err);
    apb_write(8'h30, 32'h1234_5678, err);
    check_value("unmapped write pslverr", 1, err);

    // sync-aligned capture
    apb_write(REG_CTRL, 32'h0000_0003, err);
    repeat (4) @(posedge adc_clk);
    sync_req = 1'b1;
    wait_capture_done();
    read_buffer();
    if (sync_word < 0) report_error("source never sent the sync word");
    for (int i = 0; i < CAP_DEPTH; i++) begin
      exp_s = expected_sample(rise_hist[sync_word + i], fall_hist[sync_word + i]);
      check_value($sformatf("sync capture word %0d", i), exp_s.data, cap_words[i]);
    end

    // immediate capture
    apb_write(REG_CTRL, 32'h0000_0001, err);
    wait_capture_done();
    read_buffer();
    base = -1;
    for (int n = 0; n + CAP_DEPTH <= word_cnt && base < 0; n++) begin
      exp_s = expected_sample(rise_hist[n], fall_hist[n]);
      if (exp_s.data == cap_words[0]) base = n;
    end
    if (base < 0) report_error("immediate capture word 0 matches no logged source word");
    for (int i = 1; i < CAP_DEPTH; i++) begin
      exp_s = expected_sample(rise_hist[base + i], fall_hist[base + i]);
      check_value($sformatf("immediate capture word %0d", i), exp_s.data, cap_words[i]);
    end

    // out-of-range count
    apb_write(REG_OOR_CLR, 32'h0, err);
    apb_read(REG_STATUS, rdata, err);
    check_value("oor count after clear", 0, rdata[31:16]);
    oor_left = OOR_WORDS;
    waited   = 0;
    while (oor_left != 0) begin
      waited++;
      if (waited > 100) report_error("source did not finish the out-of-range burst");
      @(posedge adc_clk);
    end
    repeat (4) @(posedge adc_clk);                     // two pipeline stages plus the counter
    apb_read(REG_STATUS, rdata, err);
    check_value("oor count after burst", OOR_WORDS, rdata[31:16]);
    apb_write(REG_OOR_CLR, 32'h0, err);
    apb_read(REG_STATUS, rdata, err);
    check_value("oor count after second clear", 0, rdata[31:16]);

    // control port
    frames_before = frame_cnt;
    apb_write(REG_CMD, CMD_WORD, err);
    check_value("cmd write pslverr", 0, err);
    apb_write(REG_CMD, 32'h0002_1111, err);
    check_value("cmd write while busy pslverr", 1, err);
    apb_read(REG_STATUS, rdata, err);
    check_value("ctrl busy during frame", 1, rdata[2]);
    waited = 0;
    while (rdata[2]) begin
      waited++;
      if (waited > 200) report_error("control port stayed busy");
      apb_read(REG_STATUS, rdata, err);
    end
    for (int i = 0; i < IDLE_CHECK; i++) begin
      @(negedge adc_clk);
      check_value("strobe_n idle after frame", 1, ctrl_strobe_n);  // a second frame pulls it low
    end
    check_value("frame count", frames_before + 1, frame_cnt);
    check_value("frame bit count", CTRL_CMD_BITS, frame_bits);
    check_value("frame address", CMD_WORD[18:16], frame_cmd.addr);
    check_value("frame data", CMD_WORD[15:0], frame_cmd.data);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* logic/iadc_top.sv */
`timescale 1ns/100ps

module iadc_top (
  input  logic                     adc_clk,
  input  logic                     rst_n,
  input  iadc_pkg::iadc_ddr_pins_t pads,
  input  iadc_pkg::apb_req_t       apb_req,
  output iadc_pkg::apb_rsp_t       apb_rsp,
  output logic                     ctrl_clk,
  output logic                     ctrl_data,
  output logic                     ctrl_strobe_n,
  output logic                     adc_mode,
  output logic                     adc_ddrb
);
  import iadc_pkg::*;

  iadc_sample_t            sample;
  iadc_ctrl_cmd_t          cmd;
  logic                    cmd_valid;
  logic                    ctrl_busy;
  logic                    arm;
  logic                    sync_en;
  logic                    oor_clear;
  logic [CAP_IDX_BITS-1:0] buf_index;
  logic [SAMPLE_BITS-1:0]  buf_word;
  logic                    cap_done;
  logic                    cap_active;
  logic [OOR_CNT_BITS-1:0] oor_count;

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////
  iadc_infrastructure u_infra (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .pads    (pads),
    .sample  (sample)
  );

  iadc_capture u_capture (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .sample    (sample),
    .arm       (arm),
    .sync_en   (sync_en),
    .oor_clear (oor_clear),
    .buf_index (buf_index),
    .buf_word  (buf_word),
    .done      (cap_done),
    .active    (cap_active),
    .oor_count (oor_count)
  );

  ////////////////////////////////////////
  // host side and adc control port
  ////////////////////////////////////////
  iadc_regs u_regs (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .arm        (arm),
    .sync_en    (sync_en),
    .oor_clear  (oor_clear),
    .buf_index  (buf_index),
    .buf_word   (buf_word),
    .cap_done   (cap_done),
    .cap_active (cap_active),
    .oor_count  (oor_count),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .ctrl_busy  (ctrl_busy),
    .adc_mode   (adc_mode),
    .adc_ddrb   (adc_ddrb)
  );

  iadc_ctrl_serial u_ctrl (
    .adc_clk       (adc_clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .busy          (ctrl_busy),
    .ctrl_clk      (ctrl_clk),
    .ctrl_data     (ctrl_data),
    .ctrl_strobe_n (ctrl_strobe_n)
  );

endmodule

/* logic/iadc_regs.sv */
`timescale 1ns/100ps

module iadc_regs (
  input  logic                              adc_clk,
  input  logic                              rst_n,
  input  iadc_pkg::apb_req_t                apb_req,
  output iadc_pkg::apb_rsp_t                apb_rsp,
  output logic                              arm,
  output logic                              sync_en,
  output logic                              oor_clear,
  output logic [iadc_pkg::CAP_IDX_BITS-1:0] buf_index,
  input  logic [iadc_pkg::SAMPLE_BITS-1:0]  buf_word,
  input  logic                              cap_done,
  input  logic                              cap_active,
  input  logic [iadc_pkg::OOR_CNT_BITS-1:0] oor_count,
  output iadc_pkg::iadc_ctrl_cmd_t          cmd,
  output logic                              cmd_valid,
  input  logic                              ctrl_busy,
  output logic                              adc_mode,
  output logic                              adc_ddrb
);
  import iadc_pkg::*;

  logic                     access;
  logic                     wr_access;
  logic                     rd_access;
  logic [APB_ADDR_BITS-1:0] buf_off;
  logic                     buf_hit;
  logic                     addr_hit;
  logic                     cmd_busy;
  logic                     cmd_write;
  logic [APB_DATA_BITS-1:0] rdata;

  assign access    = apb_req.psel && apb_req.penable;    // no wait states, access cycle completes
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  ////////////////////////////////////////
  // address decode and read mux
  ////////////////////////////////////////
  assign buf_off   = apb_req.paddr - BUF_BASE;
  assign buf_hit   = (apb_req.paddr >= BUF_BASE) &&
                     (buf_off < APB_ADDR_BITS'(8 * CAP_DEPTH)) &&
                     (buf_off[1:0] == 2'b00);
  assign buf_index = buf_off[CAP_IDX_BITS+2:3];          // two 32-bit halves per word

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (apb_req.paddr)
      REG_CTRL: begin
        rdata[3:1] = {adc_ddrb, adc_mode, sync_en};      // arm is a pulse, reads 0
      end
      REG_STATUS: begin
        rdata[31:16] = oor_count;
        rdata[2:0]   = {ctrl_busy, cap_active, cap_done};
      end
      REG_CMD, REG_OOR_CLR: begin
        rdata = '0;
      end
      default: begin
        if (buf_hit) begin
          rdata = buf_off[2] ? buf_word[63:32] : buf_word[31:0];
        end else begin
          addr_hit = 1'b0;
        end
      end
    endcase
  end

  // a pulse already on its way counts as busy too
  assign cmd_busy  = ctrl_busy || cmd_valid;
  assign cmd_write = wr_access && (apb_req.paddr == REG_CMD) && !cmd_busy;

  assign apb_rsp.prdata  = rd_access ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access &&
                           (!addr_hit || (apb_req.pwrite && apb_req.paddr == REG_CMD && cmd_busy));

  ////////////////////////////////////////
  // control bits and pulses
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      arm       <= 1'b0;
      sync_en   <= 1'b0;
      oor_clear <= 1'b0;
      cmd_valid <= 1'b0;
      adc_mode  <= 1'b0;
      adc_ddrb  <= 1'b0;
    end else begin
      arm       <= wr_access && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
      oor_clear <= wr_access && (apb_req.paddr == REG_OOR_CLR);
      cmd_valid <= cmd_write;
      if (wr_access && apb_req.paddr == REG_CTRL) begin
        {adc_ddrb, adc_mode, sync_en} <= apb_req.pwdata[3:1];
      end
    end
  end

  // address in bits 18:16 and data below, same layout as the command struct
  always_ff @(posedge adc_clk) begin
    if (cmd_write) begin
      cmd <= iadc_ctrl_cmd_t'(apb_req.pwdata[CTRL_CMD_BITS-1:0]);
    end
  end

endmodule

/* logic/iadc_capture.sv */
`timescale 1ns/100ps

module iadc_capture (
  input  logic                              adc_clk,
  input  logic                              rst_n,
  input  iadc_pkg::iadc_sample_t            sample,
  input  logic                              arm,
  input  logic                              sync_en,
  input  logic                              oor_clear,
  input  logic [iadc_pkg::CAP_IDX_BITS-1:0] buf_index,
  output logic [iadc_pkg::SAMPLE_BITS-1:0]  buf_word,
  output logic                              done,
  output logic                              active,
  output logic [iadc_pkg::OOR_CNT_BITS-1:0] oor_count
);
  import iadc_pkg::*;

  cap_state_e              state;
  logic [CAP_IDX_BITS-1:0] wr_ptr;
  logic                    wr_en;
  logic [SAMPLE_BITS-1:0]  buf_mem [CAP_DEPTH];

  // word 0 is written on the sync word itself, so the wait state also writes
  assign wr_en = !arm && ((state == CAP_FILL) || (state == CAP_WAIT_SYNC && sample.sync));

  assign done   = state == CAP_DONE;
  assign active = (state == CAP_WAIT_SYNC) || (state == CAP_FILL);

  ////////////////////////////////////////
  // snapshot control
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state  <= CAP_IDLE;
      wr_ptr <= '0;
    end else if (arm) begin
      state  <= sync_en ? CAP_WAIT_SYNC : CAP_FILL;     // re-arm also clears done
      wr_ptr <= '0;
    end else begin
      case (state)
        CAP_WAIT_SYNC: begin
          if (sample.sync) begin
            state  <= CAP_FILL;
            wr_ptr <= wr_ptr + 1'b1;
          end
        end
        CAP_FILL: begin
          wr_ptr <= wr_ptr + 1'b1;                      // wraps back to 0 on the last word
          if (wr_ptr == CAP_IDX_BITS'(CAP_DEPTH - 1)) begin
            state <= CAP_DONE;
          end
        end
        default: begin
          state <= state;                               // idle and done wait for arm
        end
      endcase
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      buf_mem[wr_ptr] <= sample.data;
    end
  end

  assign buf_word = buf_mem[buf_index];

  ////////////////////////////////////////
  // out-of-range counter
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      oor_count <= '0;
    end else if (oor_clear) begin
      oor_count <= '0;
    end else if (|sample.oor && oor_count != '1) begin
      oor_count <= oor_count + 1'b1;                    // saturates at all ones
    end
  end

endmodule

/* iadc_ctrl/iadc_ctrl_serial.sv */
`timescale 1ns/100ps

module iadc_ctrl_serial (
  input  logic                     adc_clk,
  input  logic                     rst_n,
  input  iadc_pkg::iadc_ctrl_cmd_t cmd,
  input  logic                     cmd_valid,
  output logic                     busy,
  output logic                     ctrl_clk,
  output logic                     ctrl_data,
  output logic                     ctrl_strobe_n
);
  import iadc_pkg::*;

  ctl_state_e               state;
  logic [CTRL_DIV_BITS-1:0] div_cnt;
  logic [CTRL_CNT_BITS-1:0] bit_cnt;
  logic [CTRL_CMD_BITS-1:0] shift_q;    // bits still to go, next one at the top
  logic                     half_done;
  logic                     last_bit;
  logic                     accept;
  logic                     fall_edge;

  assign half_done = div_cnt == CTRL_DIV_BITS'(CTRL_CLK_DIV - 1);
  assign last_bit  = bit_cnt == CTRL_CNT_BITS'(CTRL_CMD_BITS - 1);
  assign accept    = (state == CTL_IDLE) && !busy && cmd_valid;    // cmd_valid ignored while busy
  assign fall_edge = (state == CTL_SHIFT) && half_done && ctrl_clk;

  ////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state         <= CTL_IDLE;
      busy          <= 1'b0;
      ctrl_clk      <= 1'b0;
      ctrl_data     <= 1'b0;
      ctrl_strobe_n <= 1'b1;
      div_cnt       <= '0;
      bit_cnt       <= '0;
    end else begin
      case (state)
        CTL_IDLE: begin
          div_cnt <= '0;
          bit_cnt <= '0;
          if (busy) begin
            busy <= 1'b0;                             // one cycle after strobe_n went high
          end else if (cmd_valid) begin
            state         <= CTL_SHIFT;
            busy          <= 1'b1;
            ctrl_strobe_n <= 1'b0;
            ctrl_data     <= cmd[CTRL_CMD_BITS-1];    // msb set up while clock is low
          end
        end
        CTL_SHIFT: begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done) begin
            ctrl_clk <= ~ctrl_clk;
            if (ctrl_clk) begin                       // falling edge, bit has been sampled
              if (last_bit) begin
                state     <= CTL_END;
                ctrl_data <= 1'b0;
              end else begin
                bit_cnt   <= bit_cnt + 1'b1;
                ctrl_data <= shift_q[CTRL_CMD_BITS-1];
              end
            end
          end
        end
        CTL_END: begin
          div_cnt <= half_done ? '0 : div_cnt + 1'b1;
          if (half_done) begin
            ctrl_strobe_n <= 1'b1;                    // half period after the last fall
            state         <= CTL_IDLE;
          end
        end
        default: begin
          state <= CTL_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // shift register
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (accept) begin
      shift_q <= {cmd[CTRL_CMD_BITS-2:0], 1'b0};     // msb already on ctrl_data
    end else if (fall_edge) begin
      shift_q <= shift_q << 1;
    end
  end

endmodule

/* iadc_infrastructure/iadc_infrastructure.sv */
`timescale 1ns/100ps

module iadc_infrastructure (
  input  logic                     adc_clk,
  input  logic                     rst_n,
  input  iadc_pkg::iadc_ddr_pins_t pads,
  output iadc_pkg::iadc_sample_t   sample
);
  import iadc_pkg::*;

  iadc_ddr_pins_t pads_rise;     // bus as seen on the rising edge
  iadc_ddr_pins_t pads_fall;     // bus as seen on the following falling edge
  iadc_sample_t   sample_next;

  ////////////////////////////////////////
  // ddr input registers
  ////////////////////////////////////////

  // first stage, one register per clock edge
  always_ff @(posedge adc_clk) begin
    pads_rise <= pads;
  end

  always_ff @(negedge adc_clk) begin
    pads_fall <= pads;
  end

  ////////////////////////////////////////
  // word packing
  ////////////////////////////////////////

  // both halves land in the word on the next rising edge, same-edge pipelined style
  always_comb begin
    sample_next.data = {
      pads_rise.data_i_even,
      pads_rise.data_i_odd,
      pads_fall.data_i_even,
      pads_fall.data_i_odd,
      pads_rise.data_q_even,
      pads_rise.data_q_odd,
      pads_fall.data_q_even,
      pads_fall.data_q_odd
    };
    sample_next.oor  = {pads_fall.oor_i, pads_fall.oor_q,
                        pads_rise.oor_i, pads_rise.oor_q};
    sample_next.sync = pads_rise.sync;                       // sync only qualifies the rise half
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      sample <= '0;
    end else begin
      sample <= sample_next;                                 // new word every cycle, no stall
    end
  end

endmodule

/* common/iadc_pkg.sv */
package iadc_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////
  localparam int ADC_BITS       = 8;
  localparam int SAMPLE_BITS    = 8 * ADC_BITS;          // 4 lanes x 2 edges
  localparam int CAP_DEPTH      = 16;
  localparam int CAP_IDX_BITS   = $clog2(CAP_DEPTH);
  localparam int OOR_CNT_BITS   = 16;
  localparam int CTRL_ADDR_BITS = 3;
  localparam int CTRL_DATA_BITS = 16;
  localparam int CTRL_CMD_BITS  = CTRL_ADDR_BITS + CTRL_DATA_BITS;
  localparam int CTRL_CNT_BITS  = $clog2(CTRL_CMD_BITS);
  localparam int CTRL_CLK_DIV   = 4;                     // half period in adc_clk cycles
  localparam int CTRL_DIV_BITS  = $clog2(CTRL_CLK_DIV);
  localparam int APB_ADDR_BITS  = 8;
  localparam int APB_DATA_BITS  = 32;
  localparam logic [APB_ADDR_BITS-1:0] BUF_BASE = 8'h40;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////
  typedef struct packed {
    logic [ADC_BITS-1:0] data_i_even;
    logic [ADC_BITS-1:0] data_i_odd;
    logic [ADC_BITS-1:0] data_q_even;
    logic [ADC_BITS-1:0] data_q_odd;
    logic                oor_i;
    logic                oor_q;
    logic                sync;
  } iadc_ddr_pins_t;

  typedef struct packed {
    logic [SAMPLE_BITS-1:0] data;   // i rise/fall then q rise/fall, even before odd
    logic [3:0]             oor;    // i fall, q fall, i rise, q rise
    logic                   sync;
  } iadc_sample_t;

  typedef struct packed {
    logic [CTRL_ADDR_BITS-1:0] addr;
    logic [CTRL_DATA_BITS-1:0] data;
  } iadc_ctrl_cmd_t;

  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

  typedef enum logic [APB_ADDR_BITS-1:0] {
    REG_CTRL    = 8'h00,
    REG_STATUS  = 8'h04,
    REG_CMD     = 8'h08,
    REG_OOR_CLR = 8'h0C
  } iadc_reg_addr_e;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_WAIT_SYNC,
    CAP_FILL,
    CAP_DONE
  } cap_state_e;

  typedef enum logic [1:0] {
    CTL_IDLE,
    CTL_SHIFT,
    CTL_END
  } ctl_state_e;

endpackage
